/* verilog.f */
+incdir+.
inflight_pkg.sv
inflight_init.sv
inflight_bits.sv
inflight_bypass.sv
inflight_scoreboard.sv
tb_inflight_scoreboard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_inflight_scoreboard -o sim_inflight
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_inflight > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0

/* tb_inflight_scoreboard.sv */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight scoreboard testbench
// directed and random reads against a busy-bit model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "inflight_params.svh"

module tb_inflight_scoreboard
  import inflight_pkg::*;
();

  logic                              clk;
  logic                              rst;
  logic                              read_en;
  read_req_t [`INFL_READ_PORTS-1:0] read_req;
  done_t     [`INFL_DONE_PORTS-1:0] done;
  alloc_t                            alloc;
  logic      [`INFL_READ_PORTS-1:0] busy;
  logic                              init_busy;

  // visible busy state and the requests the DUT holds
  logic      [`INFL_REG_COUNT-1:0]  model_bits;
  read_req_t [`INFL_READ_PORTS-1:0] cap_req;
  logic      [`INFL_READ_PORTS-1:0] cap_init;
  logic      [31:0]                 rand_state;

  inflight_scoreboard i_inflight_scoreboard (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .read_req  (read_req),
    .done      (done),
    .alloc     (alloc),
    .busy      (busy),
    .init_busy (init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic read_req_t make_req(input tag_t t, input logic imm);
    read_req_t req;
    req.tag = t;
    req.imm = imm;
    return req;
  endfunction

  // a completion hides the tag from the cycle it is presented
  function automatic logic expected_busy(input int p);
    logic hit;
    hit = 1'b0;
    for (int d = 0; d < `INFL_DONE_PORTS; d++)
    begin
      if (done[d].valid && done[d].tag == cap_req[p].tag)
      begin
        hit = 1'b1;
      end
    end
    if (cap_req[p].imm || cap_init[p] || hit)
    begin
      return 1'b0;
    end
    return model_bits[cap_req[p].tag];
  endfunction

  task automatic report_value(input string name, input int exp, input int act);
    $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_plain(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic expect_now(input string name, input int p, input logic exp);
    #1;
    assert (busy[p] === exp)
    else
    begin
      report_value($sformatf("%s port %0d", name, p), int'(exp), int'(busy[p]));
    end
  endtask

  task automatic drive_idle();
    read_en = 1'b0;
    alloc   = '0;
    done    = '0;
  endtask

  // check every port, then let one edge update the model
  task automatic tick(input string name);
    #5;
    assert (!init_busy)
    else
    begin
      report_plain("init_busy came back high after the sweep");
    end
    for (int p = 0; p < `INFL_READ_PORTS; p++)
    begin
      expect_now(name, p, expected_busy(p));
    end
    @(posedge clk);
    // done clears after alloc, so a same-cycle pair ends clear
    if (alloc.valid)
    begin
      model_bits[alloc.tag] = 1'b1;
    end
    for (int d = 0; d < `INFL_DONE_PORTS; d++)
    begin
      if (done[d].valid)
      begin
        model_bits[done[d].tag] = 1'b0;
      end
    end
    if (read_en)
    begin
      cap_req  = read_req;
      cap_init = '0;
    end
    @(negedge clk);
  endtask

  initial
  begin
    int          cycles;
    logic [31:0] r;
    rst        = 1'b1;
    read_req   = '0;
    drive_idle();
    model_bits = '0;
    cap_req    = '0;
    cap_init   = '0;
    rand_state = 32'd94;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // read taken during the sweep stays 0 while held
    // an alloc during the sweep is dropped
    read_en     = 1'b1;
    alloc.valid = 1'b1;
    alloc.tag   = 5'd0;
    for (int p = 0; p < `INFL_READ_PORTS; p++)
    begin
      read_req[p] = make_req(tag_t'(p), 1'b0);
    end
    cycles = 0;
    while (init_busy && cycles < 100)
    begin
      @(posedge clk);
      if (read_en)
      begin
        cap_req  = read_req;
        cap_init = '1;
      end
      cycles++;
      @(negedge clk);
      read_en = 1'b0;
    end
    if (init_busy)
    begin
      report_plain("init_busy did not fall within 100 cycles");
    end
    assert (cycles == `INFL_REG_COUNT)
    else
    begin
      report_value("init sweep length", `INFL_REG_COUNT, cycles);
    end

    // the held sweep read ignores a later alloc
    alloc.valid = 1'b1;
    alloc.tag   = 5'd1;
    tick("read held from sweep");
    alloc = '0;
    tick("alloc under sweep read");
    done[0].valid = 1'b1;
    done[0].tag   = 5'd1;
    tick("clear after sweep read");
    done = '0;

    // every tag reads 0 after the sweep
    read_en = 1'b1;
    for (int t = 0; t <= `INFL_REG_COUNT; t++)
    begin
      for (int p = 0; p < `INFL_READ_PORTS; p++)
      begin
        read_req[p] = make_req(tag_t'(t + p), 1'b0);
      end
      tick("swept tag");
    end
    drive_idle();

    // alloc, then unallocated and immediate reads
    alloc.valid = 1'b1;
    alloc.tag   = 5'd7;
    tick("alloc");
    drive_idle();
    read_en     = 1'b1;
    read_req[0] = make_req(5'd7, 1'b0);
    read_req[1] = make_req(5'd8, 1'b0);
    read_req[2] = make_req(5'd7, 1'b1);
    tick("alloc capture");
    read_en = 1'b0;
    expect_now("allocated tag", 0, 1'b1);
    expect_now("unallocated tag", 1, 1'b0);
    expect_now("immediate", 2, 1'b0);
    tick("alloc held");

    // done while tag 7 is held on port 0
    done[0].valid = 1'b1;
    done[0].tag   = 5'd7;
    expect_now("done same cycle", 0, 1'b0);
    tick("done same cycle");
    done = '0;
    expect_now("done delay stage", 0, 1'b0);
    tick("done delay stage");
    expect_now("done stored", 0, 1'b0);
    tick("done stored");

    // alloc meets the delayed clear of the same tag
    alloc.valid = 1'b1;
    alloc.tag   = 5'd12;
    tick("alloc twelve");
    alloc         = '0;
    done[1].valid = 1'b1;
    done[1].tag   = 5'd12;
    tick("done twelve");
    done        = '0;
    alloc.valid = 1'b1;
    alloc.tag   = 5'd12;
    read_en     = 1'b1;
    read_req[1] = make_req(5'd12, 1'b0);
    tick("alloc on delayed clear");
    drive_idle();
    expect_now("alloc beats clear", 1, 1'b1);
    tick("alloc beats clear");

    for (int n = 0; n < 400; n++)
    begin
      r           = next_rand();
      alloc.valid = r[30];
      alloc.tag   = r[29:25];
      read_en     = r[24];
      for (int d = 0; d < `INFL_DONE_PORTS; d++)
      begin
        r             = next_rand();
        done[d].valid = r[30] & r[29];
        done[d].tag   = r[28:24];
      end
      for (int p = 0; p < `INFL_READ_PORTS; p++)
      begin
        r           = next_rand();
        read_req[p] = make_req(r[30:26], r[25:23] == 3'd0);
      end
      tick("random mix");
    end
    drive_idle();
    tick("idle");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* inflight_scoreboard.sv */
// ~~~~~~~~~~~~~~~~~~~~
// physical register in-flight scoreboard
// busy bit per register with read bypass
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "inflight_params.svh"

module inflight_scoreboard
  import inflight_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  read_req_t [`INFL_READ_PORTS-1:0]   read_req,
  input  done_t     [`INFL_DONE_PORTS-1:0]   done,
  input  alloc_t                              alloc,
  output logic      [`INFL_READ_PORTS-1:0]   busy,
  output logic                                init_busy
);

  logic                                sweep_we;
  tag_t                                sweep_tag;
  read_req_t [`INFL_READ_PORTS-1:0]   req_q;
  logic      [`INFL_READ_PORTS-1:0]   init_q;
  done_t     [`INFL_DONE_PORTS-1:0]   done_q;
  logic      [`INFL_READ_PORTS-1:0]   raw_bit;

  inflight_init i_inflight_init (
    .clk       (clk),
    .rst       (rst),
    .init_busy (init_busy),
    .sweep_we  (sweep_we),
    .sweep_tag (sweep_tag)
  );

  inflight_bits i_inflight_bits (
    .clk       (clk),
    .rst       (rst),
    .init_busy (init_busy),
    .sweep_we  (sweep_we),
    .sweep_tag (sweep_tag),
    .read_en   (read_en),
    .read_req  (read_req),
    .done      (done),
    .alloc     (alloc),
    .req_q     (req_q),
    .init_q    (init_q),
    .done_q    (done_q),
    .raw_bit   (raw_bit)
  );

  // one bypass per read port
  // current done goes straight in, done_q from storage
  for (genvar p = 0; p < `INFL_READ_PORTS; p++)
  begin : g_port
    inflight_bypass i_inflight_bypass (
      .req_q   (req_q[p]),
      .init_q  (init_q[p]),
      .raw_bit (raw_bit[p]),
      .done    (done),
      .done_q  (done_q),
      .busy    (busy[p])
    );
  end

endmodule

/* inflight_bypass.sv */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight read bypass
// forces a read to 0 on a pending completion
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "inflight_params.svh"

module inflight_bypass
  import inflight_pkg::*;
(
  input  read_req_t                          req_q,
  input  logic                               init_q,
  input  logic                               raw_bit,
  input  done_t     [`INFL_DONE_PORTS-1:0]  done,
  input  done_t     [`INFL_DONE_PORTS-1:0]  done_q,
  output logic                               busy
);

  logic [`INFL_DONE_PORTS-1:0] hit_now;
  logic [`INFL_DONE_PORTS-1:0] hit_late;
  logic                        cleared;

  // completion arriving this cycle
  always_comb
  begin
    for (int d = 0; d < `INFL_DONE_PORTS; d++)
    begin
      hit_now[d] = done[d].valid && (done[d].tag == req_q.tag);
    end
  end

  // completion in the delay stage, not yet in storage
  always_comb
  begin
    for (int d = 0; d < `INFL_DONE_PORTS; d++)
    begin
      hit_late[d] = done_q[d].valid && (done_q[d].tag == req_q.tag);
    end
  end

  assign cleared = |hit_now | |hit_late;

  // immediates and reads taken during the sweep are never busy
  assign busy = raw_bit & ~cleared & ~req_q.imm & ~init_q;

endmodule

/* inflight_bits.sv */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight busy bit storage
// one bit per physical register, delayed clears,
// registered read requests
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "inflight_params.svh"

module inflight_bits
  import inflight_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                init_busy,
  input  logic                                sweep_we,
  input  tag_t                                sweep_tag,
  input  logic                                read_en,
  input  read_req_t [`INFL_READ_PORTS-1:0]   read_req,
  input  done_t     [`INFL_DONE_PORTS-1:0]   done,
  input  alloc_t                              alloc,
  output read_req_t [`INFL_READ_PORTS-1:0]   req_q,
  output logic      [`INFL_READ_PORTS-1:0]   init_q,
  output done_t     [`INFL_DONE_PORTS-1:0]   done_q,
  output logic      [`INFL_READ_PORTS-1:0]   raw_bit
);

  logic [`INFL_REG_COUNT-1:0] bits_q;
  logic [`INFL_REG_COUNT-1:0] clr_vec;
  logic [`INFL_REG_COUNT-1:0] set_vec;
  logic                       alloc_take;

  // nothing is allocated until the sweep is over
  assign alloc_take = alloc.valid & ~init_busy;

  // completion delay stage
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      done_q <= '0;
    end
    else
    begin
      for (int d = 0; d < `INFL_DONE_PORTS; d++)
      begin
        done_q[d].valid <= done[d].valid & ~init_busy;
        done_q[d].tag   <= done[d].tag;
      end
    end
  end

  // clear and set masks for this edge
  always_comb
  begin
    clr_vec = '0;
    set_vec = '0;
    if (sweep_we)
    begin
      clr_vec[sweep_tag] = 1'b1;
    end
    for (int d = 0; d < `INFL_DONE_PORTS; d++)
    begin
      if (done_q[d].valid)
      begin
        clr_vec[done_q[d].tag] = 1'b1;
      end
    end
    if (alloc_take)
    begin
      set_vec[alloc.tag] = 1'b1;
    end
  end

  // set after clear, so a same-tag alloc wins
  always_ff @(posedge clk)
  begin
    bits_q <= (bits_q & ~clr_vec) | set_vec;
  end

  // requests are held until the next read_en
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req_q  <= '0;
      init_q <= '0;
    end
    else if (read_en)
    begin
      req_q  <= read_req;
      init_q <= {`INFL_READ_PORTS{init_busy}};
    end
  end

  // lookup follows storage updates while held
  always_comb
  begin
    for (int p = 0; p < `INFL_READ_PORTS; p++)
    begin
      raw_bit[p] = bits_q[req_q[p].tag];
    end
  end

endmodule

/* inflight_init.sv */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight init sweep
// clears one busy bit per cycle after reset
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "inflight_params.svh"

module inflight_init
  import inflight_pkg::*;
(
  input  logic clk,
  input  logic rst,
  output logic init_busy,
  output logic sweep_we,
  output tag_t sweep_tag
);

  localparam tag_t LAST_TAG = tag_t'(`INFL_REG_COUNT - 1);

  init_state_e state_q;
  init_state_e state_d;
  tag_t        tag_q;

  // leave the sweep once the last tag is cleared
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      INIT_SWEEP:
      begin
        if (tag_q == LAST_TAG)
        begin
          state_d = INIT_DONE;
        end
      end
      default:
      begin
        state_d = INIT_DONE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= INIT_SWEEP;
      tag_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == INIT_SWEEP)
      begin
        tag_q <= tag_q + tag_t'(1);
      end
    end
  end

  assign init_busy = (state_q == INIT_SWEEP);
  assign sweep_we  = (state_q == INIT_SWEEP);
  assign sweep_tag = tag_q;

endmodule

/* inflight_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight scoreboard types
// tags, read requests, strobes, sweep state
// ~~~~~~~~~~~~~~~~~~~~

`include "inflight_params.svh"

package inflight_pkg;

  // physical register tag
  typedef logic [`INFL_TAG_WIDTH-1:0] tag_t;

  // one operand lookup
  typedef struct packed {
    tag_t tag;
    // operand is an immediate, never busy
    logic imm;
  } read_req_t;

  // result written back, clears the busy bit
  typedef struct packed {
    logic valid;
    tag_t tag;
  } done_t;

  // destination renamed, sets the busy bit
  typedef struct packed {
    logic valid;
    tag_t tag;
  } alloc_t;

  // post-reset clearing sweep
  typedef enum logic {
    INIT_SWEEP = 1'b0,
    INIT_DONE  = 1'b1
  } init_state_e;

endpackage

/* inflight_params.svh */
// ~~~~~~~~~~~~~~~~~~~~
// in-flight scoreboard sizing
// register count, tag width and port counts
// ~~~~~~~~~~~~~~~~~~~~

`ifndef INFLIGHT_PARAMS_SVH
`define INFLIGHT_PARAMS_SVH

// physical registers tracked
`define INFL_REG_COUNT 32

// log2 of the register count
`define INFL_TAG_WIDTH 5

// operand read ports
`define INFL_READ_PORTS 3

// writeback ports that retire a pending result
`define INFL_DONE_PORTS 2

`endif
